// File: logic/fe_pkg.sv
package fe_pkg;

  // fetch address after reset
  localparam logic [31:0] RESET_PC = 32'h0;

  // instruction memory in 32-bit words
  localparam int IMEM_WORDS = 64;
  localparam int IMEM_AW = $clog2(IMEM_WORDS);
  // pc wraps inside the memory image
  localparam logic [31:0] PC_MASK = 32'(IMEM_WORDS * 4 - 1);

  // decoded bundle buffer
  localparam int FIFO_DEPTH = 8;
  localparam int FIFO_AW = $clog2(FIFO_DEPTH);

  // from inst[31:26]
  typedef enum logic [2:0] {
    OP_ALU     = 3'd0,
    OP_LOAD    = 3'd1,
    OP_STORE   = 3'd2,
    OP_BRANCH  = 3'd3,
    OP_JUMP    = 3'd4,
    OP_ILLEGAL = 3'd5
  } opcode_e;

  typedef struct packed {
    logic [31:0] pc;
    logic [1:0]  mask;
  } fetch_req_t;

  // pc bit 2 set when slot 0 came from the odd word
  typedef struct packed {
    logic [31:0]      pc;
    logic [1:0][31:0] inst;
    logic [1:0]       mask;
  } fetch_bundle_t;

  typedef struct packed {
    logic [31:0] pc;
    opcode_e     op;
    logic [4:0]  rd;
    logic        illegal;
  } ctrl_pack_t;

  typedef struct packed {
    ctrl_pack_t [1:0] p;
    logic [1:0]       mask;
  } decode_bundle_t;

endpackage

// File: logic/fe_pc_gen.sv
`timescale 1ns/1ps

module fe_pc_gen (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               fetch_en_i,
  input  logic               flush_i,
  input  logic [31:0]        redirect_pc_i,
  input  logic               ready_i,
  output logic               valid_o,
  output fe_pkg::fetch_req_t req_o
);

  import fe_pkg::*;

  logic [31:0] pc_q;
  logic [1:0]  mask_q;
  logic        valid_q;
  logic        fire;

  assign fire = valid_q && ready_i;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      pc_q    <= RESET_PC;
      mask_q  <= 2'b11;
      valid_q <= 1'b0;
    end
    else if (flush_i)
    begin
      // restart at the bundle holding the target
      pc_q    <= {redirect_pc_i[31:3], 3'b000} & PC_MASK;
      mask_q  <= redirect_pc_i[2] ? 2'b10 : 2'b11;
      valid_q <= fetch_en_i;
    end
    else if (fire)
    begin
      pc_q    <= (pc_q + 32'd8) & PC_MASK;
      mask_q  <= 2'b11;
      valid_q <= fetch_en_i;
    end
    else if (!valid_q)
    begin
      valid_q <= fetch_en_i;
    end
  end

  assign valid_o    = valid_q;
  assign req_o.pc   = pc_q;
  assign req_o.mask = mask_q;

  // request must not change until taken
  a_req_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    valid_o && !ready_i && !flush_i |=> valid_o && $stable(req_o)
  );

endmodule

// File: logic/fe_skid_buf.sv
`timescale 1ns/1ps

module fe_skid_buf #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     flush_i,
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  logic     ready_q;
  payload_t skid_q;

  // low while an item sits in the skid register
  always_ff @(posedge clk)
  begin
    if (!rst_n || flush_i)
    begin
      ready_q <= 1'b1;
    end
    else if (ready_q)
    begin
      ready_q <= !(valid_i && !ready_i);
    end
    else
    begin
      ready_q <= ready_i;
    end
  end

  always_ff @(posedge clk)
  begin
    if (ready_q)
    begin
      skid_q <= data_i;
    end
  end

  assign ready_o = ready_q;
  assign valid_o = ready_q ? valid_i : 1'b1;
  assign data_o  = ready_q ? data_i : skid_q;

endmodule

// File: logic/fe_fetch_stage.sv
`timescale 1ns/1ps

module fe_fetch_stage (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  flush_i,
  input  logic                  valid_i,
  output logic                  ready_o,
  input  fe_pkg::fetch_req_t    req_i,
  output logic                  valid_o,
  input  logic                  ready_i,
  output fe_pkg::fetch_bundle_t bundle_o,
  input  logic                  imem_we_i,
  input  logic [5:0]            imem_addr_i,
  input  logic [31:0]           imem_wdata_i
);

  import fe_pkg::*;

  logic [31:0]          imem_q [IMEM_WORDS];
  logic [IMEM_AW-2:0]   line;
  logic                 accept;
  logic                 valid_q;
  fetch_bundle_t        raw_q;

  // two words per bundle line
  assign line   = req_i.pc[IMEM_AW+1:3];
  assign accept = valid_i && ready_o;

  always_ff @(posedge clk)
  begin
    if (imem_we_i)
    begin
      imem_q[imem_addr_i] <= imem_wdata_i;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n || flush_i)
    begin
      valid_q <= 1'b0;
    end
    else if (accept)
    begin
      valid_q <= 1'b1;
    end
    else if (ready_i)
    begin
      valid_q <= 1'b0;
    end
  end

  // bundle read is held while stalled
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      raw_q.pc      <= req_i.pc;
      raw_q.mask    <= req_i.mask;
      raw_q.inst[0] <= imem_q[{line, 1'b0}];
      raw_q.inst[1] <= imem_q[{line, 1'b1}];
    end
  end

  assign ready_o = !valid_q || ready_i;
  assign valid_o = valid_q;

  // lone odd slot moves down to slot 0
  always_comb
  begin
    bundle_o = raw_q;
    if (!raw_q.mask[0])
    begin
      bundle_o.pc[2]   = 1'b1;
      bundle_o.inst[0] = raw_q.inst[1];
      bundle_o.mask    = {1'b0, raw_q.mask[1]};
    end
  end

  a_mask_nonzero: assert property (
    @(posedge clk) disable iff (!rst_n)
    accept && !flush_i |-> req_i.mask != 2'b00
  );

endmodule

// File: logic/fe_decode_stage.sv
`timescale 1ns/1ps

module fe_decode_stage (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   flush_i,
  input  logic                   valid_i,
  output logic                   ready_o,
  input  fe_pkg::fetch_bundle_t  bundle_i,
  output logic                   valid_o,
  input  logic                   ready_i,
  output fe_pkg::decode_bundle_t dec_o
);

  import fe_pkg::*;

  logic          valid_q;
  fetch_bundle_t bundle_q;

  function automatic opcode_e decode_op(input logic [31:0] inst);
    opcode_e op;
    case (inst[31:26])
      6'h01:   op = OP_ALU;
      6'h02:   op = OP_LOAD;
      6'h03:   op = OP_STORE;
      6'h04:   op = OP_BRANCH;
      6'h05:   op = OP_JUMP;
      default: op = OP_ILLEGAL;
    endcase
    return op;
  endfunction

  // empty or draining this cycle
  assign ready_o = !valid_q || ready_i;
  assign valid_o = valid_q;

  always_ff @(posedge clk)
  begin
    if (!rst_n || flush_i)
    begin
      valid_q <= 1'b0;
    end
    else if (ready_o)
    begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk)
  begin
    if (valid_i && ready_o)
    begin
      bundle_q <= bundle_i;
    end
  end

  always_comb
  begin
    dec_o.mask = bundle_q.mask;
    for (int i = 0; i < 2; i++)
    begin
      dec_o.p[i].op      = decode_op(bundle_q.inst[i]);
      dec_o.p[i].rd      = bundle_q.inst[i][4:0];
      dec_o.p[i].illegal = (dec_o.p[i].op == OP_ILLEGAL);
    end
    // slot 0 keeps the bundle pc, slot 1 is always the odd word
    dec_o.p[0].pc = bundle_q.pc;
    dec_o.p[1].pc = {bundle_q.pc[31:3], 1'b1, bundle_q.pc[1:0]};
  end

endmodule

// File: logic/fe_pkg_fifo.sv
`timescale 1ns/1ps

module fe_pkg_fifo (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   flush_i,
  input  logic                   valid_i,
  output logic                   ready_o,
  input  fe_pkg::decode_bundle_t data_i,
  output logic                   valid_o,
  input  logic                   ready_i,
  output fe_pkg::decode_bundle_t data_o
);

  import fe_pkg::*;

  decode_bundle_t     mem_q [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wptr_q;
  logic [FIFO_AW-1:0] rptr_q;
  logic [FIFO_AW:0]   count_q;
  logic               push;
  logic               pop;

  assign ready_o = (count_q != (FIFO_AW + 1)'(FIFO_DEPTH));
  assign valid_o = (count_q != '0);
  assign data_o  = mem_q[rptr_q];
  assign push    = valid_i && ready_o;
  assign pop     = valid_o && ready_i;

  always_ff @(posedge clk)
  begin
    if (!rst_n || flush_i)
    begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end
    else
    begin
      if (push)
      begin
        wptr_q <= wptr_q + 1'b1;
      end
      if (pop)
      begin
        rptr_q <= rptr_q + 1'b1;
      end
      count_q <= count_q + {{FIFO_AW{1'b0}}, push} - {{FIFO_AW{1'b0}}, pop};
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      mem_q[wptr_q] <= data_i;
    end
  end

  a_no_overflow: assert property (
    @(posedge clk) disable iff (!rst_n)
    count_q <= (FIFO_AW + 1)'(FIFO_DEPTH)
  );

  // a pop from empty would leave count wrapped
  a_no_underflow: assert property (
    @(posedge clk) disable iff (!rst_n)
    !flush_i && count_q == '0 |=> count_q <= 1
  );

endmodule

// File: logic/fe_frontend.sv
`timescale 1ns/1ps

module fe_frontend (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     fetch_en_i,
  input  logic                     redirect_valid_i,
  input  logic [31:0]              redirect_pc_i,
  input  logic                     imem_we_i,
  input  logic [5:0]               imem_addr_i,
  input  logic [31:0]              imem_wdata_i,
  output logic                     pkg_valid_o,
  input  logic                     pkg_ready_i,
  output logic [1:0]               pkg_mask_o,
  output fe_pkg::ctrl_pack_t [1:0] pkg_o
);

  import fe_pkg::*;

  logic           flush;
  logic           pc_valid, pc_ready;
  logic           req_valid, req_ready;
  logic           ft_valid, ft_ready;
  logic           bnd_valid, bnd_ready;
  logic           dec_valid, dec_ready;
  fetch_req_t     pc_req, req;
  fetch_bundle_t  ft_bundle, bundle;
  decode_bundle_t dec, fifo_out;

  // redirect clears every stage
  assign flush = redirect_valid_i;

  fe_pc_gen u_pc_gen (
    .clk(clk), .rst_n(rst_n), .fetch_en_i(fetch_en_i), .flush_i(flush),
    .redirect_pc_i(redirect_pc_i), .ready_i(pc_ready), .valid_o(pc_valid), .req_o(pc_req)
  );

  fe_skid_buf #(.payload_t(fetch_req_t)) u_req_skid (
    .clk(clk), .rst_n(rst_n), .flush_i(flush),
    .valid_i(pc_valid), .ready_o(pc_ready), .data_i(pc_req),
    .valid_o(req_valid), .ready_i(req_ready), .data_o(req)
  );

  fe_fetch_stage u_fetch (
    .clk(clk), .rst_n(rst_n), .flush_i(flush),
    .valid_i(req_valid), .ready_o(req_ready), .req_i(req),
    .valid_o(ft_valid), .ready_i(ft_ready), .bundle_o(ft_bundle),
    .imem_we_i(imem_we_i), .imem_addr_i(imem_addr_i), .imem_wdata_i(imem_wdata_i)
  );

  fe_skid_buf #(.payload_t(fetch_bundle_t)) u_bundle_skid (
    .clk(clk), .rst_n(rst_n), .flush_i(flush),
    .valid_i(ft_valid), .ready_o(ft_ready), .data_i(ft_bundle),
    .valid_o(bnd_valid), .ready_i(bnd_ready), .data_o(bundle)
  );

  fe_decode_stage u_decode (
    .clk(clk), .rst_n(rst_n), .flush_i(flush),
    .valid_i(bnd_valid), .ready_o(bnd_ready), .bundle_i(bundle),
    .valid_o(dec_valid), .ready_i(dec_ready), .dec_o(dec)
  );

  fe_pkg_fifo u_pkg_fifo (
    .clk(clk), .rst_n(rst_n), .flush_i(flush),
    .valid_i(dec_valid), .ready_o(dec_ready), .data_i(dec),
    .valid_o(pkg_valid_o), .ready_i(pkg_ready_i), .data_o(fifo_out)
  );

  assign pkg_o      = fifo_out.p;
  assign pkg_mask_o = fifo_out.mask;

endmodule

// File: test/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // 20 ns period
  initial
  begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  initial
  begin
    rst_n_o = 1'b0;
    repeat (16) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

// File: test/tb_frontend.sv
`timescale 1ns/1ps

module tb_frontend;

  import fe_pkg::*;

  logic               clk;
  logic               rst_n;
  logic               fetch_en_i;
  logic               redirect_valid_i;
  logic [31:0]        redirect_pc_i;
  logic               imem_we_i;
  logic [5:0]         imem_addr_i;
  logic [31:0]        imem_wdata_i;
  logic               pkg_valid_o;
  logic               pkg_ready_i;
  logic [1:0]         pkg_mask_o;
  ctrl_pack_t [1:0]   pkg_o;

  // memory image as written through the port
  logic [31:0] image [IMEM_WORDS];
  // aligned pc of the next expected bundle
  logic [31:0] exp_pc;
  logic        exp_odd;
  int          illegal_seen;

  tb_clock_gen u_clk (.clk_o(clk), .rst_n_o(rst_n));

  fe_frontend UUT (
    .clk(clk), .rst_n(rst_n), .fetch_en_i(fetch_en_i),
    .redirect_valid_i(redirect_valid_i), .redirect_pc_i(redirect_pc_i),
    .imem_we_i(imem_we_i), .imem_addr_i(imem_addr_i), .imem_wdata_i(imem_wdata_i),
    .pkg_valid_o(pkg_valid_o), .pkg_ready_i(pkg_ready_i),
    .pkg_mask_o(pkg_mask_o), .pkg_o(pkg_o)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1, "run aborted");
  endtask

  task automatic check(input string name, input logic [63:0] expected,
                       input logic [63:0] actual);
    if (expected !== actual)
    begin
      $display("** Error %s: expected %0h, actual %0h", name, expected, actual);
      abort_run("value mismatch");
    end
  endtask

  // byte address space of 256
  function automatic logic [31:0] wrap_pc(input logic [31:0] pc);
    return pc % 32'd256;
  endfunction

  function automatic opcode_e opcode_of(input logic [31:0] inst);
    case (inst[31:26])
      6'h01:   return OP_ALU;
      6'h02:   return OP_LOAD;
      6'h03:   return OP_STORE;
      6'h04:   return OP_BRANCH;
      6'h05:   return OP_JUMP;
      default: return OP_ILLEGAL;
    endcase
  endfunction

  function automatic ctrl_pack_t expected_pack(input logic [31:0] pc);
    ctrl_pack_t  p;
    logic [31:0] inst;
    inst      = image[pc[7:2]];
    p.pc      = pc;
    p.op      = opcode_of(inst);
    p.rd      = inst[4:0];
    p.illegal = (p.op == OP_ILLEGAL);
    return p;
  endfunction

  // compare the bundle on the port with the model, then step the model
  task automatic verify_bundle(input string name);
    logic [1:0] mask;
    ctrl_pack_t p0;
    ctrl_pack_t p1;
    mask = exp_odd ? 2'b01 : 2'b11;
    p0   = expected_pack(exp_odd ? exp_pc + 32'd4 : exp_pc);
    p1   = expected_pack(exp_pc + 32'd4);
    check({name, " mask"}, 64'(mask), 64'(pkg_mask_o));
    check({name, " slot0"}, 64'(p0), 64'(pkg_o[0]));
    if (pkg_o[0].illegal)
    begin
      illegal_seen++;
    end
    if (mask[1])
    begin
      check({name, " slot1"}, 64'(p1), 64'(pkg_o[1]));
      if (pkg_o[1].illegal)
      begin
        illegal_seen++;
      end
    end
    exp_pc  = wrap_pc(exp_pc + 32'd8);
    exp_odd = 1'b0;
  endtask

  task automatic collect(input string name, input int count, input int ready_pct);
    int got;
    int idle;
    got  = 0;
    idle = 0;
    while (got < count)
    begin
      @(negedge clk);
      pkg_ready_i = ($urandom_range(99) < ready_pct);
      if (pkg_valid_o && pkg_ready_i)
      begin
        verify_bundle(name);
        got++;
        idle = 0;
      end
      else
      begin
        idle++;
        if (idle > 40)
        begin
          abort_run($sformatf("%s: no bundle arrived, %0d of %0d taken", name, got, count));
        end
      end
    end
  endtask

  task automatic wait_valid(input string name, input int limit);
    int n;
    n = 0;
    while (!pkg_valid_o)
    begin
      @(negedge clk);
      pkg_ready_i = 1'b0;
      n++;
      if (n > limit)
      begin
        abort_run($sformatf("%s: pkg_valid_o did not rise within %0d cycles", name, limit));
      end
    end
  endtask

  // stop fetch, flush everything, then fetch again from target
  task automatic restart_at(input logic [31:0] target);
    @(negedge clk);
    fetch_en_i       = 1'b0;
    pkg_ready_i      = 1'b0;
    redirect_valid_i = 1'b1;
    redirect_pc_i    = target;
    @(negedge clk);
    redirect_valid_i = 1'b0;
    check("restart", 64'(1'b0), 64'(pkg_valid_o));
    exp_pc     = wrap_pc({target[31:3], 3'b000});
    exp_odd    = target[2];
    fetch_en_i = 1'b1;
  endtask

  task automatic reset_idle();
    int          n;
    logic [31:0] rnd;
    logic [5:0]  opc;
    n = 0;
    @(negedge clk);
    while (!rst_n)
    begin
      check("reset_idle", 64'(1'b0), 64'(pkg_valid_o));
      @(negedge clk);
      n++;
      if (n > 40)
      begin
        abort_run("reset_idle: reset never released");
      end
    end
    for (int i = 0; i < IMEM_WORDS; i++)
    begin
      rnd = $urandom;
      opc = 6'(1 + i % 5);
      case (i)
        19:      opc = 6'h00;
        22:      opc = 6'h3f;
        28:      opc = 6'h2a;
        45:      opc = 6'h06;
        default: ;
      endcase
      image[i] = {opc, 6'(i), rnd[14:0], rnd[19:15]};
      @(negedge clk);
      imem_we_i    = 1'b1;
      imem_addr_i  = 6'(i);
      imem_wdata_i = image[i];
      check("reset_idle", 64'(1'b0), 64'(pkg_valid_o));
    end
    @(negedge clk);
    imem_we_i = 1'b0;
    check("reset_idle", 64'(1'b0), 64'(pkg_valid_o));
  endtask

  task automatic sequential_fetch();
    exp_pc  = RESET_PC;
    exp_odd = 1'b0;
    @(negedge clk);
    fetch_en_i = 1'b1;
    wait_valid("sequential", 10);
    collect("sequential", 12, 100);
  endtask

  task automatic illegal_decode();
    restart_at(32'h40);
    illegal_seen = 0;
    collect("illegal", 8, 100);
    // words 19, 22 and 28 carry unlisted opcodes
    check("illegal count", 64'(3), 64'(illegal_seen));
  endtask

  task automatic random_backpressure();
    restart_at(RESET_PC);
    // crosses the pc wrap
    collect("backpressure", 40, 50);
  endtask

  task automatic fill_drain();
    logic [63:0] held0;
    logic [63:0] held1;
    logic [1:0]  held_mask;
    restart_at(32'h80);
    wait_valid("fill_drain", 10);
    held0     = 64'(pkg_o[0]);
    held1     = 64'(pkg_o[1]);
    held_mask = pkg_mask_o;
    repeat (30)
    begin
      @(negedge clk);
      pkg_ready_i = 1'b0;
      check("fill_drain valid", 64'(1'b1), 64'(pkg_valid_o));
      check("fill_drain slot0", held0, 64'(pkg_o[0]));
      check("fill_drain slot1", held1, 64'(pkg_o[1]));
      check("fill_drain mask", 64'(held_mask), 64'(pkg_mask_o));
    end
    collect("fill_drain", 20, 100);
  endtask

  task automatic redirect_odd();
    restart_at(RESET_PC);
    collect("redirect_odd pre", 5, 100);
    @(negedge clk);
    pkg_ready_i      = 1'b0;
    redirect_valid_i = 1'b1;
    redirect_pc_i    = 32'h2c;
    @(negedge clk);
    redirect_valid_i = 1'b0;
    check("redirect_odd flush", 64'(1'b0), 64'(pkg_valid_o));
    exp_pc  = 32'h28;
    exp_odd = 1'b1;
    collect("redirect_odd", 10, 70);
  endtask

  initial
  begin
    void'($urandom(32'h38e8_861d));
    fetch_en_i       = 1'b0;
    redirect_valid_i = 1'b0;
    redirect_pc_i    = '0;
    imem_we_i        = 1'b0;
    imem_addr_i      = '0;
    imem_wdata_i     = '0;
    pkg_ready_i      = 1'b0;
    exp_pc           = RESET_PC;
    exp_odd          = 1'b0;
    illegal_seen     = 0;
    reset_idle();
    sequential_fetch();
    illegal_decode();
    random_backpressure();
    fill_drain();
    redirect_odd();
    $display("Verification passed");
    $finish;
  end

endmodule

// File: tb.f
logic/fe_pkg.sv
logic/fe_pc_gen.sv
logic/fe_skid_buf.sv
logic/fe_fetch_stage.sv
logic/fe_decode_stage.sv
logic/fe_pkg_fifo.sv
logic/fe_frontend.sv
test/tb_clock_gen.sv
test/tb_frontend.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f tb.f --top-module tb_frontend -o tb_frontend
	./obj_dir/tb_frontend | tee /dev/stderr | grep -q "Verification passed"

clean:
	rm -rf obj_dir
